// File: include/rate_params.svh
// widths, per-axis gains, shifts and limits shared by the rate controller RTL and testbench
`ifndef RATE_PARAMS_SVH
`define RATE_PARAMS_SVH

`define RATE_W      16       // signed rate or angle error
`define IMU_W       16       // signed gyro reading
`define SUM_W       20       // internal sums, headroom over RATE_W
`define MOTOR_W     12       // unsigned throttle and motor command

`define RATE_MIN    (-2048)  // pid output clamp
`define RATE_MAX    2047
`define MOTOR_MAX   4095     // lower motor limit is 0

`define PITCH_K_P   6
`define PITCH_K_I   2
`define PITCH_K_D   4
`define ROLL_K_P    5
`define ROLL_K_I    1
`define ROLL_K_D    3

`define K_P_SHIFT   4
`define K_I_SHIFT   4
`define K_D_SHIFT   4
`define PID_LATENCY 5        // start edge to pid done
`endif

// File: verilog/imu_pkg.sv
// sensor-side packed types for one axis sample and the full flight sample, imported by the RTL
`default_nettype none
`include "rate_params.svh"

package imu_pkg;

  // one axis worth of loop inputs
  typedef struct packed {
    logic signed [`RATE_W-1:0] angle_error;      // from the outer angle loop
    logic signed [`RATE_W-1:0] target_rotation;  // commanded rate
    logic signed [`IMU_W-1:0]  actual_rotation;  // gyro reading
  } axis_sample_t;

  // what the top level latches on start
  typedef struct packed {
    axis_sample_t        pitch;
    axis_sample_t        roll;
    logic [`MOTOR_W-1:0] throttle;  // collective, unsigned
  } flight_sample_t;

endpackage

`default_nettype wire

// File: verilog/motor_pkg.sv
// actuator-side packed types for pid rate corrections and X-frame motor commands
`default_nettype none
`include "rate_params.svh"

package motor_pkg;

  // clamped pid correction
  typedef logic signed [`RATE_W-1:0] axis_rate_t;

  // X-frame order, clockwise from front left
  typedef struct packed {
    logic [`MOTOR_W-1:0] front_left;
    logic [`MOTOR_W-1:0] front_right;
    logic [`MOTOR_W-1:0] rear_right;
    logic [`MOTOR_W-1:0] rear_left;
  } motor_cmd_t;

endpackage

`default_nettype wire

// File: verilog/pid.sv
// single-axis rate PID, one instance per axis, runs a fixed five-step sequence per start strobe
`timescale 1ns/1ps
`default_nettype none
`include "rate_params.svh"

module pid #(
  parameter int K_P = 1,
  parameter int K_I = 1,
  parameter int K_D = 1
) (
  input  logic                  us_clk,
  input  logic                  resetn,
  input  logic                  start,
  input  imu_pkg::axis_sample_t sample,
  output logic                  busy,
  output logic                  done,
  output motor_pkg::axis_rate_t rate
);
  import imu_pkg::*;
  import motor_pkg::*;

  typedef enum logic [5:0] {
    S_WAIT     = 6'b000001,
    S_CALC1    = 6'b000010,
    S_CALC2    = 6'b000100,
    S_CALC3    = 6'b001000,
    S_CALC4    = 6'b010000,
    S_COMPLETE = 6'b100000
  } state_t;

  state_t state, state_nxt;

  axis_sample_t sample_q;  // held for the whole sequence

  logic signed [`SUM_W-1:0] rot_err;        // target minus actual
  logic signed [`SUM_W-1:0] prev_err;       // from the previous command
  logic signed [`SUM_W-1:0] err_change;
  logic signed [`SUM_W-1:0] p_term;
  logic signed [`SUM_W-1:0] i_term;
  logic signed [`SUM_W-1:0] d_term;
  logic signed [`SUM_W-1:0] total;
  logic signed [`SUM_W-1:0] total_clamped;

  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      state <= S_WAIT;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    unique case (state)
      S_WAIT:     state_nxt = start ? S_CALC1 : S_WAIT;
      S_CALC1:    state_nxt = S_CALC2;
      S_CALC2:    state_nxt = S_CALC3;
      S_CALC3:    state_nxt = S_CALC4;
      S_CALC4:    state_nxt = S_COMPLETE;
      S_COMPLETE: state_nxt = S_WAIT;  // back to idle right away
      default:    state_nxt = S_WAIT;
    endcase
  end

  // saturate to the rate range before it leaves the block
  always_comb begin
    if (total < `RATE_MIN) begin
      total_clamped = `SUM_W'(`RATE_MIN);
    end else if (total > `RATE_MAX) begin
      total_clamped = `SUM_W'(`RATE_MAX);
    end else begin
      total_clamped = total;
    end
  end

  // error history and outputs
  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      rot_err  <= '0;
      prev_err <= '0;
      done     <= 1'b0;
      rate     <= '0;
    end else begin
      done <= (state == S_COMPLETE);  // one cycle, lands after COMPLETE
      if (state == S_CALC1) begin
        prev_err <= rot_err;
        rot_err  <= `SUM_W'(sample_q.target_rotation) - `SUM_W'(sample_q.actual_rotation);
      end
      if (state == S_COMPLETE) begin
        rate <= axis_rate_t'(total_clamped);
      end
    end
  end

  // working terms
  always_ff @(posedge us_clk) begin
    if (state == S_WAIT && start) begin
      sample_q <= sample;
    end
    unique case (state)
      S_CALC1: begin
        // integral taken from the angle error, no accumulator
        i_term <= `SUM_W'((K_I * sample_q.angle_error) >>> `K_I_SHIFT);
      end
      S_CALC2: begin
        p_term     <= `SUM_W'((K_P * rot_err) >>> `K_P_SHIFT);
        err_change <= rot_err - prev_err;
      end
      S_CALC3: begin
        d_term <= `SUM_W'((K_D * err_change) >>> `K_D_SHIFT);
      end
      S_CALC4: begin
        total <= p_term + i_term + d_term;
      end
      default: begin
      end
    endcase
  end

  assign busy = (state != S_WAIT) || done;  // stays up until done has dropped

endmodule

`default_nettype wire

// File: verilog/motor_mixer.sv
// X-frame motor mixer, waits for both pid results and registers four clamped motor commands
`timescale 1ns/1ps
`default_nettype none
`include "rate_params.svh"

module motor_mixer (
  input  logic                  us_clk,
  input  logic                  resetn,
  input  logic                  start,
  input  logic [`MOTOR_W-1:0]   throttle,
  input  logic                  pitch_done,
  input  logic                  roll_done,
  input  motor_pkg::axis_rate_t pitch_rate,
  input  motor_pkg::axis_rate_t roll_rate,
  output logic                  pending,
  output logic                  cmd_valid,
  output motor_pkg::motor_cmd_t cmd
);
  import motor_pkg::*;

  logic [`MOTOR_W-1:0]      throttle_q;
  logic signed [`SUM_W-1:0] thr_s;
  logic signed [`SUM_W-1:0] pitch_s;
  logic signed [`SUM_W-1:0] roll_s;
  logic                     mix_now;
  motor_cmd_t               cmd_nxt;

  function automatic logic [`MOTOR_W-1:0] clamp_motor(input logic signed [`SUM_W-1:0] mix);
    if (mix < 0) begin
      return '0;
    end else if (mix > `MOTOR_MAX) begin
      return `MOTOR_W'(`MOTOR_MAX);
    end
    return mix[`MOTOR_W-1:0];
  endfunction

  // widen everything before adding
  assign thr_s   = $signed({{(`SUM_W-`MOTOR_W){1'b0}}, throttle_q});
  assign pitch_s = `SUM_W'(pitch_rate);
  assign roll_s  = `SUM_W'(roll_rate);

  assign mix_now = pending && pitch_done && roll_done;

  always_comb begin
    cmd_nxt.front_left  = clamp_motor(thr_s + pitch_s + roll_s);
    cmd_nxt.front_right = clamp_motor(thr_s + pitch_s - roll_s);
    cmd_nxt.rear_right  = clamp_motor(thr_s - pitch_s - roll_s);
    cmd_nxt.rear_left   = clamp_motor(thr_s - pitch_s + roll_s);
  end

  always_ff @(posedge us_clk) begin
    if (start) begin
      throttle_q <= throttle;
    end
  end

  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      pending   <= 1'b0;
      cmd_valid <= 1'b0;
      cmd       <= '0;
    end else begin
      cmd_valid <= mix_now;
      if (mix_now) begin
        cmd <= cmd_nxt;  // holds until the next result
      end
      if (cmd_valid) begin
        pending <= 1'b0;  // released once the strobe has gone out
      end else if (start) begin
        pending <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/rate_controller.sv
// top level of the two-axis rate controller, pitch and roll PIDs feeding the motor mixer
`timescale 1ns/1ps
`default_nettype none
`include "rate_params.svh"

module rate_controller (
  input  logic                     us_clk,
  input  logic                     resetn,
  input  logic                     start,
  input  imu_pkg::flight_sample_t  sample,
  output logic                     busy,
  output logic                     cmd_valid,
  output motor_pkg::motor_cmd_t    cmd
);
  import motor_pkg::*;

  logic       start_ok;  // strobe seen by the sub-blocks
  logic       pitch_busy;
  logic       pitch_done;
  logic       roll_done;
  logic       pending;
  axis_rate_t pitch_rate;
  axis_rate_t roll_rate;

  assign start_ok = start && !busy;
  assign busy     = pitch_busy || pending;  // both pids run in lockstep

  pid #(.K_P(`PITCH_K_P), .K_I(`PITCH_K_I), .K_D(`PITCH_K_D)) u_pitch_pid (
    .us_clk(us_clk), .resetn(resetn), .start(start_ok), .sample(sample.pitch),
    .busy(pitch_busy), .done(pitch_done), .rate(pitch_rate)
  );

  pid #(.K_P(`ROLL_K_P), .K_I(`ROLL_K_I), .K_D(`ROLL_K_D)) u_roll_pid (
    .us_clk(us_clk), .resetn(resetn), .start(start_ok), .sample(sample.roll),
    .busy(), .done(roll_done), .rate(roll_rate)
  );

  motor_mixer u_mixer (
    .us_clk(us_clk), .resetn(resetn), .start(start_ok), .throttle(sample.throttle),
    .pitch_done(pitch_done), .roll_done(roll_done),
    .pitch_rate(pitch_rate), .roll_rate(roll_rate),
    .pending(pending), .cmd_valid(cmd_valid), .cmd(cmd)
  );

endmodule

`default_nettype wire

// File: sim/rate_controller_properties.sv
// handshake and reset assertions for the rate controller, attached to the RTL top level by bind
`timescale 1ns/1ps
`default_nettype none
`include "rate_params.svh"

module rate_controller_properties (
  input logic us_clk,
  input logic resetn,
  input logic start,
  input logic busy,
  input logic cmd_valid
);

  logic accepted;

  assign accepted = start && !busy;  // same gating as the top level

  a_valid_single: assert property (@(posedge us_clk) disable iff (!resetn)
    cmd_valid |=> !cmd_valid)
    else $error("cmd_valid stayed high for more than one cycle");

  // rises six edges after the accepting edge and is seen one edge later, both directions
  a_valid_latency: assert property (@(posedge us_clk) disable iff (!resetn)
    cmd_valid == $past(accepted, `PID_LATENCY + 2))
    else $error("cmd_valid does not line up with an accepted start");

  a_busy_falls: assert property (@(posedge us_clk) disable iff (!resetn)
    cmd_valid |=> !busy)
    else $error("busy did not fall after cmd_valid");

  a_reset_quiet: assert property (@(posedge us_clk) !resetn |-> !cmd_valid)
    else $error("cmd_valid high during reset");

endmodule

bind rate_controller rate_controller_properties u_props (
  .us_clk(us_clk), .resetn(resetn), .start(start), .busy(busy), .cmd_valid(cmd_valid)
);

`default_nettype wire

// File: sim/rate_controller_tb.sv
// directed and random tests for the rate controller, results checked against a reference model
`timescale 1ns/1ps
`default_nettype none
`include "rate_params.svh"

module rate_controller_tb;
  import imu_pkg::*;
  import motor_pkg::*;

  localparam int TIMEOUT = 50;  // cycles allowed per wait

  logic           us_clk;
  logic           resetn;
  logic           start;
  flight_sample_t sample;
  logic           busy;
  logic           cmd_valid;
  motor_cmd_t     cmd;

  int          pitch_prev;   // model error history
  int          roll_prev;
  int          model_pitch;  // last predicted pid rates
  int          model_roll;
  logic [31:0] rng;

  rate_controller u_dut (
    .us_clk(us_clk), .resetn(resetn), .start(start), .sample(sample),
    .busy(busy), .cmd_valid(cmd_valid), .cmd(cmd)
  );

  always #2 us_clk = ~us_clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // signed field with a random magnitude scale
  function automatic logic [15:0] random_field();
    rng = xorshift(rng);
    return 16'($signed(rng[15:0]) >>> rng[18:16]);
  endfunction

  function automatic int clamp(input int v, input int lo, input int hi);
    if (v < lo) begin
      return lo;
    end
    if (v > hi) begin
      return hi;
    end
    return v;
  endfunction

  function automatic int rot_error(input axis_sample_t s);
    return int'($signed(s.target_rotation)) - int'($signed(s.actual_rotation));
  endfunction

  // integral from the angle error, derivative from the saved error
  function automatic int axis_rate(input axis_sample_t s, input int prev, input int k_p,
                                   input int k_i, input int k_d);
    int err;
    int p;
    int i;
    int d;
    err = rot_error(s);
    i   = (k_i * int'($signed(s.angle_error))) >>> `K_I_SHIFT;
    p   = (k_p * err) >>> `K_P_SHIFT;
    d   = (k_d * (err - prev)) >>> `K_D_SHIFT;
    return clamp(p + i + d, `RATE_MIN, `RATE_MAX);
  endfunction

  function automatic flight_sample_t make_sample(input int pa, input int pt, input int pm,
                                                 input int ra, input int rt, input int rm,
                                                 input int thr);
    flight_sample_t s;
    s.pitch.angle_error     = `RATE_W'(pa);
    s.pitch.target_rotation = `RATE_W'(pt);
    s.pitch.actual_rotation = `IMU_W'(pm);
    s.roll.angle_error      = `RATE_W'(ra);
    s.roll.target_rotation  = `RATE_W'(rt);
    s.roll.actual_rotation  = `IMU_W'(rm);
    s.throttle              = `MOTOR_W'(thr);
    return s;
  endfunction

  task automatic predict(input flight_sample_t s, output motor_cmd_t exp_cmd);
    int thr;
    thr         = int'(s.throttle);
    model_pitch = axis_rate(s.pitch, pitch_prev, `PITCH_K_P, `PITCH_K_I, `PITCH_K_D);
    model_roll  = axis_rate(s.roll, roll_prev, `ROLL_K_P, `ROLL_K_I, `ROLL_K_D);
    pitch_prev  = rot_error(s.pitch);
    roll_prev   = rot_error(s.roll);
    exp_cmd.front_left  = `MOTOR_W'(clamp(thr + model_pitch + model_roll, 0, `MOTOR_MAX));
    exp_cmd.front_right = `MOTOR_W'(clamp(thr + model_pitch - model_roll, 0, `MOTOR_MAX));
    exp_cmd.rear_right  = `MOTOR_W'(clamp(thr - model_pitch - model_roll, 0, `MOTOR_MAX));
    exp_cmd.rear_left   = `MOTOR_W'(clamp(thr - model_pitch + model_roll, 0, `MOTOR_MAX));
  endtask

  task automatic check(input string name, input logic signed [63:0] expected,
                       input logic signed [63:0] actual);
    if (expected !== actual) begin
      $display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "check failed");
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timed out waiting for %s", what);
    $display("TEST FAILED");
    $fatal(1, "timeout");
  endtask

  task automatic wait_idle(input string name);
    int n;
    n = 0;
    while (busy && n < TIMEOUT) begin
      @(negedge us_clk);
      n++;
    end
    if (busy) begin
      timeout_fail({name, ": busy to fall"});
    end
  endtask

  // leaves the caller on the falling edge after the sampling edge
  task automatic pulse_start(input flight_sample_t s);
    @(negedge us_clk);
    sample = s;
    start  = 1'b1;
    @(negedge us_clk);
    start  = 1'b0;
  endtask

  task automatic run_command(input string name, input flight_sample_t s);
    motor_cmd_t exp_cmd;
    int         cycles;
    predict(s, exp_cmd);
    pulse_start(s);
    cycles = 0;
    while (!cmd_valid && cycles < TIMEOUT) begin
      @(negedge us_clk);
      cycles++;
    end
    if (!cmd_valid) begin
      timeout_fail({name, ": cmd_valid"});
    end
    check({name, " latency"}, `PID_LATENCY + 1, cycles);
    check({name, " pitch rate"}, model_pitch, u_dut.u_pitch_pid.rate);
    check({name, " roll rate"}, model_roll, u_dut.u_roll_pid.rate);
    check(name, exp_cmd, cmd);
    wait_idle(name);
  endtask

  task automatic test_reset();
    check("reset busy", 0, busy);
    check("reset cmd_valid", 0, cmd_valid);
    check("reset cmd", 0, cmd);
  endtask

  task automatic test_consecutive();
    run_command("consecutive 1", make_sample(60, 300, 200, -40, -100, -60, 1800));
    run_command("consecutive 2", make_sample(60, 300, 260, -40, -100, -140, 1800));
  endtask

  task automatic test_saturation();
    run_command("saturate high", make_sample(32767, 30000, -30000, 32767, 30000, -30000, 4095));
    check("saturate high pitch", `RATE_MAX, u_dut.u_pitch_pid.rate);
    check("saturate high roll", `RATE_MAX, u_dut.u_roll_pid.rate);
    check("saturate high front_left", `MOTOR_MAX, cmd.front_left);
    run_command("saturate low", make_sample(-32768, -30000, 30000, -32768, -30000, 30000, 0));
    check("saturate low pitch", `RATE_MIN, u_dut.u_pitch_pid.rate);
    check("saturate low roll", `RATE_MIN, u_dut.u_roll_pid.rate);
    check("saturate low front_left", 0, cmd.front_left);
  endtask

  task automatic test_busy_start();
    flight_sample_t first;
    flight_sample_t second;
    motor_cmd_t     exp_cmd;
    motor_cmd_t     got;
    int             pulses;
    int             n;
    first  = make_sample(120, 50, -20, 90, 10, 70, 2500);
    second = make_sample(-900, -700, 800, 600, 900, -900, 300);
    got    = '0;
    predict(first, exp_cmd);
    pulse_start(first);
    pulse_start(second);  // lands in CALC2, must be dropped
    pulses = 0;
    n      = 0;
    while (n < 20) begin  // long enough for a second result to show up
      if (cmd_valid) begin
        pulses++;
        got = cmd;
      end
      @(negedge us_clk);
      n++;
    end
    check("busy start pulses", 1, pulses);
    check("busy start cmd", exp_cmd, got);
    check("busy start idle", 0, busy);
  endtask

  task automatic test_random();
    flight_sample_t s;
    for (int k = 0; k < 40; k++) begin
      s.pitch.angle_error     = random_field();
      s.pitch.target_rotation = random_field();
      s.pitch.actual_rotation = random_field();
      s.roll.angle_error      = random_field();
      s.roll.target_rotation  = random_field();
      s.roll.actual_rotation  = random_field();
      rng        = xorshift(rng);
      s.throttle = rng[`MOTOR_W-1:0];
      run_command($sformatf("random %0d", k), s);
    end
  endtask

  initial begin
    us_clk     = 1'b0;
    resetn     = 1'b0;
    start      = 1'b0;
    sample     = '0;
    pitch_prev = 0;
    roll_prev  = 0;
    rng        = 32'h4047_b0e5;
    repeat (5) @(posedge us_clk);
    @(negedge us_clk);
    resetn = 1'b1;
    @(negedge us_clk);
    test_reset();
    run_command("single", make_sample(40, 120, 100, -30, -50, -80, 2000));
    test_consecutive();
    test_saturation();
    test_busy_start();
    test_random();
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: drone_rate.f
+incdir+include
verilog/imu_pkg.sv
verilog/motor_pkg.sv
verilog/pid.sv
verilog/motor_mixer.sv
verilog/rate_controller.sv
sim/rate_controller_properties.sv
sim/rate_controller_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f drone_rate.f \
  --top-module rate_controller_tb \
  -o rate_controller_sim

out=$(./obj_dir/rate_controller_sim 2>&1) || { echo "$out"; exit 1; }
echo "$out"

echo "$out" | grep -q "TEST PASSED"
